// ==== rv32_config.svh ====
`ifndef RV32_CONFIG_SVH
`define RV32_CONFIG_SVH

`define RV32_XLEN              32
`define RV32_NUM_REGS          32

// Major opcodes
`define RV32_OPC_LUI           7'b0110111
`define RV32_OPC_AUIPC         7'b0010111
`define RV32_OPC_JAL           7'b1101111
`define RV32_OPC_JALR          7'b1100111
`define RV32_OPC_BRANCH        7'b1100011
`define RV32_OPC_LOAD          7'b0000011
`define RV32_OPC_STORE         7'b0100011
`define RV32_OPC_OP_IMM        7'b0010011
`define RV32_OPC_OP            7'b0110011
`define RV32_OPC_MISC_MEM      7'b0001111

// Wildcards for casez matching
`define RV32_F3_ANY            3'b???
`define RV32_F7_ANY            7'b???????

`define RV32_F3_JALR           3'b000

`define RV32_F3_BEQ            3'b000
`define RV32_F3_BNE            3'b001
`define RV32_F3_BLT            3'b100
`define RV32_F3_BGE            3'b101
`define RV32_F3_BLTU           3'b110
`define RV32_F3_BGEU           3'b111

`define RV32_F3_LB             3'b000
`define RV32_F3_LH             3'b001
`define RV32_F3_LW             3'b010
`define RV32_F3_LBU            3'b100
`define RV32_F3_LHU            3'b101

`define RV32_F3_SB             3'b000
`define RV32_F3_SH             3'b001
`define RV32_F3_SW             3'b010

// OP and OP-IMM share these
`define RV32_F3_ADD_SUB        3'b000
`define RV32_F3_SLL            3'b001
`define RV32_F3_SLT            3'b010
`define RV32_F3_SLTU           3'b011
`define RV32_F3_XOR            3'b100
`define RV32_F3_SRL_SRA        3'b101
`define RV32_F3_OR             3'b110
`define RV32_F3_AND            3'b111

`define RV32_F3_FENCE          3'b000
`define RV32_F3_FENCE_I        3'b001

`define RV32_F7_ZERO           7'b0000000
`define RV32_F7_ALT            7'b0100000

`define RV32_ALU_ADD_SUB       4'd0
`define RV32_ALU_XOR           4'd1
`define RV32_ALU_OR            4'd2
`define RV32_ALU_AND           4'd3
`define RV32_ALU_SLL           4'd4
`define RV32_ALU_SRL_SRA       4'd5
`define RV32_ALU_SLT           4'd6
`define RV32_ALU_SLTU          4'd7
`define RV32_ALU_SRC2          4'd8
`define RV32_ALU_SRC1P4        4'd9

// Same values as funct3[1:0] of loads and stores
`define RV32_MEM_BYTE          2'd0
`define RV32_MEM_HALF          2'd1
`define RV32_MEM_WORD          2'd2

`define RV32_BR_NEVER          2'd0
`define RV32_BR_ZERO           2'd1
`define RV32_BR_NON_ZERO       2'd2
`define RV32_BR_ALWAYS         2'd3

`define RV32_IMM_NONE          3'd0
`define RV32_IMM_I             3'd1
`define RV32_IMM_S             3'd2
`define RV32_IMM_B             3'd3
`define RV32_IMM_U             3'd4
`define RV32_IMM_J             3'd5
`define RV32_IMM_SHAMT         3'd6

// Operand and target selects
`define RV32_SRC1_REG          1'b0
`define RV32_SRC1_PC           1'b1
`define RV32_SRC2_REG          1'b0
`define RV32_SRC2_IMM          1'b1
`define RV32_PC_SRC_IMM        1'b0
`define RV32_PC_SRC_REG        1'b1

`endif

// ==== rv32_isa_pkg.sv ====
`include "rv32_config.svh"

package rv32_isa_pkg;

    // Data and address words
    typedef logic [`RV32_XLEN-1:0] word_t;

    // Register index, 5 bits for 32 registers
    typedef logic [$clog2(`RV32_NUM_REGS)-1:0] reg_addr_t;

    // Instruction word fields
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // Immediate format select, see RV32_IMM_* codes
    typedef logic [2:0] imm_fmt_t;

endpackage

// ==== rv32_ctrl_pkg.sv ====
package rv32_ctrl_pkg;

    import rv32_isa_pkg::*;

    // Encodings are the RV32_ALU_* codes
    typedef logic [3:0] alu_op_t;

    // Encodings are the RV32_MEM_* codes
    typedef logic [1:0] mem_width_t;

    // Encodings are the RV32_BR_* codes
    typedef logic [1:0] branch_op_t;

    // Control bundle handed to execute
    typedef struct packed {
        logic       valid;
        alu_op_t    alu_op;
        logic       alu_sub_sra;
        // 0 selects rs1, 1 the PC
        logic       alu_src1;
        // 0 selects rs2, 1 the immediate
        logic       alu_src2;
        logic       mem_read;
        logic       mem_write;
        mem_width_t mem_width;
        logic       mem_zero_extend;
        branch_op_t branch_op;
        // Target base, 0 is PC plus immediate, 1 is the register
        logic       branch_pc_src;
        logic       rd_write;
    } ctrl_t;

    // Writeback port into the register file
    typedef struct packed {
        reg_addr_t rd;
        logic      rd_write;
        word_t     rd_value;
    } wb_t;

endpackage

// ==== rv32_regs.sv ====
`timescale 1ns/1ns
`include "rv32_config.svh"

module rv32_regs (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    stall_i,
    input  rv32_isa_pkg::reg_addr_t rs1_i,
    input  rv32_isa_pkg::reg_addr_t rs2_i,
    input  rv32_ctrl_pkg::wb_t      wb_i,
    output rv32_isa_pkg::word_t     rs1_value_o,
    output rv32_isa_pkg::word_t     rs2_value_o
);
    import rv32_isa_pkg::*;

    word_t regs_q [`RV32_NUM_REGS];

    // x0 is hardwired, a write in the same cycle wins over the array
    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (wb_i.rd_write && (wb_i.rd == addr)) begin
            return wb_i.rd_value;
        end
        return regs_q[addr];
    endfunction

    // Writes go through even while the stage is stalled
    always_ff @(posedge clk) begin
        if (wb_i.rd_write && (wb_i.rd != '0)) begin
            regs_q[wb_i.rd] <= wb_i.rd_value;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rs1_value_o <= '0;
            rs2_value_o <= '0;
        end else if (!stall_i) begin
            rs1_value_o <= read_port(rs1_i);
            rs2_value_o <= read_port(rs2_i);
        end
    end

endmodule

// ==== rv32_imm_gen.sv ====
`timescale 1ns/1ns
`include "rv32_config.svh"

module rv32_imm_gen (
    input  rv32_isa_pkg::word_t    instr_i,
    input  rv32_isa_pkg::imm_fmt_t imm_fmt_i,
    output rv32_isa_pkg::word_t    imm_o
);
    import rv32_isa_pkg::*;

    logic  sign;
    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;
    word_t imm_shamt;

    assign sign = instr_i[31];

    assign imm_i = {{21{sign}}, instr_i[30:20]};
    assign imm_s = {{21{sign}}, instr_i[30:25], instr_i[11:7]};
    assign imm_b = {{20{sign}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{12{sign}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

    // Shift amount sits in the rs2 field
    assign imm_shamt = {27'b0, instr_i[24:20]};

    always_comb begin
        case (imm_fmt_i)
            `RV32_IMM_I:     imm_o = imm_i;
            `RV32_IMM_S:     imm_o = imm_s;
            `RV32_IMM_B:     imm_o = imm_b;
            `RV32_IMM_U:     imm_o = imm_u;
            `RV32_IMM_J:     imm_o = imm_j;
            `RV32_IMM_SHAMT: imm_o = imm_shamt;
            default:         imm_o = '0;
        endcase
    end

endmodule

// ==== rv32_ctrl_decode.sv ====
`timescale 1ns/1ns
`include "rv32_config.svh"

module rv32_ctrl_decode (
    input  rv32_isa_pkg::word_t    instr_i,
    output rv32_ctrl_pkg::ctrl_t   ctrl_o,
    output rv32_isa_pkg::imm_fmt_t imm_fmt_o
);
    import rv32_isa_pkg::*;
    import rv32_ctrl_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;
    logic    is_cmp;
    logic    is_alt;

    // ALU operation shared by OP and OP-IMM
    function automatic alu_op_t alu_of_f3(input funct3_t f3);
        case (f3)
            `RV32_F3_ADD_SUB: return `RV32_ALU_ADD_SUB;
            `RV32_F3_SLL:     return `RV32_ALU_SLL;
            `RV32_F3_SLT:     return `RV32_ALU_SLT;
            `RV32_F3_SLTU:    return `RV32_ALU_SLTU;
            `RV32_F3_XOR:     return `RV32_ALU_XOR;
            `RV32_F3_SRL_SRA: return `RV32_ALU_SRL_SRA;
            `RV32_F3_OR:      return `RV32_ALU_OR;
            default:          return `RV32_ALU_AND;
        endcase
    endfunction

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // Compares run the ALU as a subtraction
    assign is_cmp = (funct3 == `RV32_F3_SLT) || (funct3 == `RV32_F3_SLTU);
    assign is_alt = (funct7 == `RV32_F7_ALT);

    always_comb begin
        ctrl_o    = '0;
        imm_fmt_o = `RV32_IMM_NONE;

        casez ({opcode, funct3, funct7})
            {`RV32_OPC_LUI, `RV32_F3_ANY, `RV32_F7_ANY}: begin
                ctrl_o.valid    = 1'b1;
                ctrl_o.alu_op   = `RV32_ALU_SRC2;
                ctrl_o.alu_src2 = `RV32_SRC2_IMM;
                ctrl_o.rd_write = 1'b1;
                imm_fmt_o       = `RV32_IMM_U;
            end
            {`RV32_OPC_AUIPC, `RV32_F3_ANY, `RV32_F7_ANY}: begin
                ctrl_o.valid    = 1'b1;
                ctrl_o.alu_op   = `RV32_ALU_ADD_SUB;
                ctrl_o.alu_src1 = `RV32_SRC1_PC;
                ctrl_o.alu_src2 = `RV32_SRC2_IMM;
                ctrl_o.rd_write = 1'b1;
                imm_fmt_o       = `RV32_IMM_U;
            end
            // Jumps write PC plus 4 to rd
            {`RV32_OPC_JAL, `RV32_F3_ANY, `RV32_F7_ANY},
            {`RV32_OPC_JALR, `RV32_F3_JALR, `RV32_F7_ANY}: begin
                ctrl_o.valid     = 1'b1;
                ctrl_o.alu_op    = `RV32_ALU_SRC1P4;
                ctrl_o.alu_src1  = `RV32_SRC1_PC;
                ctrl_o.branch_op = `RV32_BR_ALWAYS;
                ctrl_o.rd_write  = 1'b1;
                if (opcode == `RV32_OPC_JALR) begin
                    ctrl_o.branch_pc_src = `RV32_PC_SRC_REG;
                    imm_fmt_o            = `RV32_IMM_I;
                end else begin
                    ctrl_o.branch_pc_src = `RV32_PC_SRC_IMM;
                    imm_fmt_o            = `RV32_IMM_J;
                end
            end
            {`RV32_OPC_BRANCH, `RV32_F3_BEQ, `RV32_F7_ANY},
            {`RV32_OPC_BRANCH, `RV32_F3_BNE, `RV32_F7_ANY},
            {`RV32_OPC_BRANCH, `RV32_F3_BLT, `RV32_F7_ANY},
            {`RV32_OPC_BRANCH, `RV32_F3_BGE, `RV32_F7_ANY},
            {`RV32_OPC_BRANCH, `RV32_F3_BLTU, `RV32_F7_ANY},
            {`RV32_OPC_BRANCH, `RV32_F3_BGEU, `RV32_F7_ANY}: begin
                ctrl_o.valid       = 1'b1;
                ctrl_o.alu_sub_sra = 1'b1;
                ctrl_o.alu_src1    = `RV32_SRC1_REG;
                ctrl_o.alu_src2    = `RV32_SRC2_REG;
                case (funct3[2:1])
                    2'b00:   ctrl_o.alu_op = `RV32_ALU_ADD_SUB;
                    2'b10:   ctrl_o.alu_op = `RV32_ALU_SLT;
                    default: ctrl_o.alu_op = `RV32_ALU_SLTU;
                endcase
                // BNE, BLT and BLTU take the branch on a nonzero result
                ctrl_o.branch_op     = (funct3[0] ^ funct3[2]) ? `RV32_BR_NON_ZERO
                                                               : `RV32_BR_ZERO;
                ctrl_o.branch_pc_src = `RV32_PC_SRC_IMM;
                imm_fmt_o            = `RV32_IMM_B;
            end
            {`RV32_OPC_LOAD, `RV32_F3_LB, `RV32_F7_ANY},
            {`RV32_OPC_LOAD, `RV32_F3_LH, `RV32_F7_ANY},
            {`RV32_OPC_LOAD, `RV32_F3_LW, `RV32_F7_ANY},
            {`RV32_OPC_LOAD, `RV32_F3_LBU, `RV32_F7_ANY},
            {`RV32_OPC_LOAD, `RV32_F3_LHU, `RV32_F7_ANY}: begin
                ctrl_o.valid           = 1'b1;
                ctrl_o.alu_op          = `RV32_ALU_ADD_SUB;
                ctrl_o.alu_src2        = `RV32_SRC2_IMM;
                ctrl_o.mem_read        = 1'b1;
                ctrl_o.mem_width       = mem_width_t'(funct3[1:0]);
                ctrl_o.mem_zero_extend = funct3[2];
                ctrl_o.rd_write        = 1'b1;
                imm_fmt_o              = `RV32_IMM_I;
            end
            {`RV32_OPC_STORE, `RV32_F3_SB, `RV32_F7_ANY},
            {`RV32_OPC_STORE, `RV32_F3_SH, `RV32_F7_ANY},
            {`RV32_OPC_STORE, `RV32_F3_SW, `RV32_F7_ANY}: begin
                ctrl_o.valid     = 1'b1;
                ctrl_o.alu_op    = `RV32_ALU_ADD_SUB;
                ctrl_o.alu_src2  = `RV32_SRC2_IMM;
                ctrl_o.mem_write = 1'b1;
                ctrl_o.mem_width = mem_width_t'(funct3[1:0]);
                imm_fmt_o        = `RV32_IMM_S;
            end
            {`RV32_OPC_OP_IMM, `RV32_F3_ADD_SUB, `RV32_F7_ANY},
            {`RV32_OPC_OP_IMM, `RV32_F3_SLT, `RV32_F7_ANY},
            {`RV32_OPC_OP_IMM, `RV32_F3_SLTU, `RV32_F7_ANY},
            {`RV32_OPC_OP_IMM, `RV32_F3_XOR, `RV32_F7_ANY},
            {`RV32_OPC_OP_IMM, `RV32_F3_OR, `RV32_F7_ANY},
            {`RV32_OPC_OP_IMM, `RV32_F3_AND, `RV32_F7_ANY},
            {`RV32_OPC_OP_IMM, `RV32_F3_SLL, `RV32_F7_ZERO},
            {`RV32_OPC_OP_IMM, `RV32_F3_SRL_SRA, `RV32_F7_ZERO},
            {`RV32_OPC_OP_IMM, `RV32_F3_SRL_SRA, `RV32_F7_ALT}: begin
                ctrl_o.valid       = 1'b1;
                ctrl_o.alu_op      = alu_of_f3(funct3);
                // funct7 only means SRAI here, for ADDI it is immediate bits
                ctrl_o.alu_sub_sra = is_cmp || (is_alt && (funct3 == `RV32_F3_SRL_SRA));
                ctrl_o.alu_src2    = `RV32_SRC2_IMM;
                ctrl_o.rd_write    = 1'b1;
                if ((funct3 == `RV32_F3_SLL) || (funct3 == `RV32_F3_SRL_SRA)) begin
                    imm_fmt_o = `RV32_IMM_SHAMT;
                end else begin
                    imm_fmt_o = `RV32_IMM_I;
                end
            end
            {`RV32_OPC_OP, `RV32_F3_ADD_SUB, `RV32_F7_ZERO},
            {`RV32_OPC_OP, `RV32_F3_ADD_SUB, `RV32_F7_ALT},
            {`RV32_OPC_OP, `RV32_F3_SLL, `RV32_F7_ZERO},
            {`RV32_OPC_OP, `RV32_F3_SLT, `RV32_F7_ZERO},
            {`RV32_OPC_OP, `RV32_F3_SLTU, `RV32_F7_ZERO},
            {`RV32_OPC_OP, `RV32_F3_XOR, `RV32_F7_ZERO},
            {`RV32_OPC_OP, `RV32_F3_SRL_SRA, `RV32_F7_ZERO},
            {`RV32_OPC_OP, `RV32_F3_SRL_SRA, `RV32_F7_ALT},
            {`RV32_OPC_OP, `RV32_F3_OR, `RV32_F7_ZERO},
            {`RV32_OPC_OP, `RV32_F3_AND, `RV32_F7_ZERO}: begin
                ctrl_o.valid       = 1'b1;
                ctrl_o.alu_op      = alu_of_f3(funct3);
                ctrl_o.alu_sub_sra = is_cmp || is_alt;
                ctrl_o.alu_src2    = `RV32_SRC2_REG;
                ctrl_o.rd_write    = 1'b1;
            end
            // Nothing to do for fences in an in-order pipeline
            {`RV32_OPC_MISC_MEM, `RV32_F3_FENCE, `RV32_F7_ANY},
            {`RV32_OPC_MISC_MEM, `RV32_F3_FENCE_I, `RV32_F7_ANY}: begin
                ctrl_o.valid = 1'b1;
            end
            default: begin
                ctrl_o    = '0;
                imm_fmt_o = `RV32_IMM_NONE;
            end
        endcase
    end

endmodule

// ==== rv32_decode.sv ====
`timescale 1ns/1ns
`include "rv32_config.svh"

module rv32_decode (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    stall_i,
    input  logic                    flush_i,
    input  rv32_isa_pkg::word_t     pc_i,
    input  rv32_isa_pkg::word_t     instr_i,
    input  rv32_ctrl_pkg::wb_t      wb_i,
    output rv32_isa_pkg::reg_addr_t rs1_unreg_o,
    output rv32_isa_pkg::reg_addr_t rs2_unreg_o,
    output rv32_ctrl_pkg::ctrl_t    ctrl_o,
    output rv32_isa_pkg::reg_addr_t rs1_o,
    output rv32_isa_pkg::reg_addr_t rs2_o,
    output rv32_isa_pkg::reg_addr_t rd_o,
    output rv32_isa_pkg::word_t     pc_o,
    output rv32_isa_pkg::word_t     imm_o,
    output rv32_isa_pkg::word_t     rs1_value_o,
    output rv32_isa_pkg::word_t     rs2_value_o
);
    import rv32_isa_pkg::*;
    import rv32_ctrl_pkg::*;

    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    ctrl_t     dec_ctrl;
    ctrl_t     cap_ctrl;
    imm_fmt_t  imm_fmt;
    word_t     imm;

    assign rs1 = instr_i[19:15];
    assign rs2 = instr_i[24:20];
    assign rd  = instr_i[11:7];

    // Hazard unit sees the fields before the pipeline register
    assign rs1_unreg_o = rs1;
    assign rs2_unreg_o = rs2;

    rv32_ctrl_decode u_ctrl_decode (
        .instr_i   (instr_i),
        .ctrl_o    (dec_ctrl),
        .imm_fmt_o (imm_fmt)
    );

    rv32_imm_gen u_imm_gen (
        .instr_i   (instr_i),
        .imm_fmt_i (imm_fmt),
        .imm_o     (imm)
    );

    rv32_regs u_regs (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .stall_i     (stall_i),
        .rs1_i       (rs1),
        .rs2_i       (rs2),
        .wb_i        (wb_i),
        .rs1_value_o (rs1_value_o),
        .rs2_value_o (rs2_value_o)
    );

    // Flush kills side effects but keeps the decoded valid bit
    always_comb begin
        cap_ctrl = dec_ctrl;
        if (flush_i) begin
            cap_ctrl.mem_read  = 1'b0;
            cap_ctrl.mem_write = 1'b0;
            cap_ctrl.rd_write  = 1'b0;
            cap_ctrl.branch_op = `RV32_BR_NEVER;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctrl_o <= '0;
            rs1_o  <= '0;
            rs2_o  <= '0;
            rd_o   <= '0;
            pc_o   <= '0;
            imm_o  <= '0;
        end else if (!stall_i) begin
            ctrl_o <= cap_ctrl;
            rs1_o  <= rs1;
            rs2_o  <= rs2;
            rd_o   <= rd;
            pc_o   <= pc_i;
            imm_o  <= imm;
        end
    end

endmodule

// ==== tb_rv32_ref.svh ====
`ifndef TB_RV32_REF_SVH
`define TB_RV32_REF_SVH

// Random instruction of one group, group 9 and above is a fence
function automatic word_t make_instr(input int group, input word_t r);
    word_t   w;
    funct3_t f3;
    funct7_t f7;
    w  = r;
    f3 = r[14:12];
    f7 = r[31:25];
    case (group)
        0: w[6:0] = `RV32_OPC_LUI;
        1: w[6:0] = `RV32_OPC_AUIPC;
        2: w[6:0] = `RV32_OPC_JAL;
        3: begin
            w[6:0] = `RV32_OPC_JALR;
            f3     = 3'd0;
        end
        4: begin
            w[6:0] = `RV32_OPC_BRANCH;
            if (f3[2:1] == 2'b01) begin
                f3[1] = 1'b0;
            end
        end
        5: begin
            w[6:0] = `RV32_OPC_LOAD;
            if (f3 > 3'd5 || f3 == 3'd3) begin
                f3 = 3'd2;
            end
        end
        6: begin
            w[6:0] = `RV32_OPC_STORE;
            f3     = f3 % 3;
        end
        7: begin
            w[6:0] = `RV32_OPC_OP_IMM;
            if (f3 == 3'd1) begin
                f7 = `RV32_F7_ZERO;
            end else if (f3 == 3'd5) begin
                f7 = r[30] ? `RV32_F7_ALT : `RV32_F7_ZERO;
            end
        end
        8: begin
            w[6:0] = `RV32_OPC_OP;
            f7 = ((f3 == 3'd0 || f3 == 3'd5) && r[30]) ? `RV32_F7_ALT : `RV32_F7_ZERO;
        end
        default: begin
            w[6:0] = `RV32_OPC_MISC_MEM;
            f3     = {2'b00, r[12]};
        end
    endcase
    w[14:12] = f3;
    w[31:25] = f7;
    return w;
endfunction

// Expected control bundle straight from the RV32I table
function automatic ctrl_t expect_ctrl(input word_t w);
    ctrl_t   c;
    funct3_t f3;
    funct7_t f7;
    logic    alt;
    c   = '0;
    f3  = w[14:12];
    f7  = w[31:25];
    alt = (f7 == `RV32_F7_ALT);
    case (w[6:0])
        `RV32_OPC_LUI: begin
            c.valid = 1; c.alu_op = `RV32_ALU_SRC2; c.alu_src2 = 1; c.rd_write = 1;
        end
        `RV32_OPC_AUIPC: begin
            c.valid = 1; c.alu_src1 = 1; c.alu_src2 = 1; c.rd_write = 1;
        end
        `RV32_OPC_JAL, `RV32_OPC_JALR: begin
            if (w[6:0] == `RV32_OPC_JAL || f3 == 3'd0) begin
                c.valid = 1; c.alu_op = `RV32_ALU_SRC1P4; c.alu_src1 = 1;
                c.branch_op = `RV32_BR_ALWAYS; c.rd_write = 1;
                c.branch_pc_src = (w[6:0] == `RV32_OPC_JALR);
            end
        end
        `RV32_OPC_BRANCH: begin
            if (f3 != 3'd2 && f3 != 3'd3) begin
                c.valid = 1; c.alu_sub_sra = 1;
                c.alu_op = (f3 < 3'd4) ? `RV32_ALU_ADD_SUB :
                           (f3 < 3'd6) ? `RV32_ALU_SLT : `RV32_ALU_SLTU;
                // BNE, BLT, BLTU
                c.branch_op = (f3 == 3'd1 || f3 == 3'd4 || f3 == 3'd6) ?
                              `RV32_BR_NON_ZERO : `RV32_BR_ZERO;
            end
        end
        `RV32_OPC_LOAD: begin
            if (f3 != 3'd3 && f3 < 3'd6) begin
                c.valid = 1; c.alu_src2 = 1; c.mem_read = 1; c.rd_write = 1;
                c.mem_width = f3[1:0]; c.mem_zero_extend = f3[2];
            end
        end
        `RV32_OPC_STORE: begin
            if (f3 < 3'd3) begin
                c.valid = 1; c.alu_src2 = 1; c.mem_write = 1; c.mem_width = f3[1:0];
            end
        end
        `RV32_OPC_OP_IMM, `RV32_OPC_OP: begin
            c.valid = 1; c.rd_write = 1;
            c.alu_src2 = (w[6:0] == `RV32_OPC_OP_IMM);
            case (f3)
                3'd0: c.alu_op = `RV32_ALU_ADD_SUB;
                3'd1: c.alu_op = `RV32_ALU_SLL;
                3'd2: c.alu_op = `RV32_ALU_SLT;
                3'd3: c.alu_op = `RV32_ALU_SLTU;
                3'd4: c.alu_op = `RV32_ALU_XOR;
                3'd5: c.alu_op = `RV32_ALU_SRL_SRA;
                3'd6: c.alu_op = `RV32_ALU_OR;
                default: c.alu_op = `RV32_ALU_AND;
            endcase
            c.alu_sub_sra = (f3 == 3'd2) || (f3 == 3'd3) || (f3 == 3'd5 && alt) ||
                            (w[6:0] == `RV32_OPC_OP && f3 == 3'd0 && alt);
            if (w[6:0] == `RV32_OPC_OP_IMM) begin
                if ((f3 == 3'd1 && f7 != 0) || (f3 == 3'd5 && f7 != 0 && !alt)) begin
                    c = '0;
                end
            end else if (f7 != 0 && !(alt && (f3 == 3'd0 || f3 == 3'd5))) begin
                c = '0;
            end
        end
        `RV32_OPC_MISC_MEM: c.valid = (f3 < 3'd2);
        default: c = '0;
    endcase
    return c;
endfunction

function automatic word_t expect_imm(input word_t w);
    ctrl_t c;
    c = expect_ctrl(w);
    if (!c.valid) begin
        return '0;
    end
    case (w[6:0])
        `RV32_OPC_LUI, `RV32_OPC_AUIPC: return {w[31:12], 12'h000};
        `RV32_OPC_JAL: return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        `RV32_OPC_BRANCH: return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        `RV32_OPC_STORE: return {{20{w[31]}}, w[31:25], w[11:7]};
        `RV32_OPC_JALR, `RV32_OPC_LOAD: return {{20{w[31]}}, w[31:20]};
        `RV32_OPC_OP_IMM: begin
            if (w[13:12] == 2'b01) begin
                return {27'd0, w[24:20]};
            end
            return {{20{w[31]}}, w[31:20]};
        end
        default: return '0;
    endcase
endfunction

`endif

// ==== tb_rv32_decode.sv ====
`timescale 1ns/1ns
`include "rv32_config.svh"

module tb_rv32_decode;
    import rv32_isa_pkg::*;
    import rv32_ctrl_pkg::*;

    `include "tb_rv32_ref.svh"

    logic      clk;
    logic      rst_n_i;
    logic      stall_i;
    logic      flush_i;
    word_t     pc_i;
    word_t     instr_i;
    wb_t       wb_i;
    reg_addr_t rs1_unreg_o;
    reg_addr_t rs2_unreg_o;
    ctrl_t     ctrl_o;
    reg_addr_t rs1_o;
    reg_addr_t rs2_o;
    reg_addr_t rd_o;
    word_t     pc_o;
    word_t     imm_o;
    word_t     rs1_value_o;
    word_t     rs2_value_o;

    logic [31:0] rng_state = 32'hc54b;
    word_t       reg_model [32];

    rv32_decode dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Watchdog for the whole run
    initial begin
        int cycles;
        for (cycles = 0; cycles < 20000; cycles++) begin
            @(posedge clk);
        end
        $display("Timeout: the test did not finish within 20000 cycles");
        $display("STATUS: FAIL");
        $fatal(1);
    end

    function automatic logic [31:0] xorshift();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check(input string name, input logic [37:0] exp, input logic [37:0] act);
        assert (act === exp) else begin
            $display("Fail at %0t: %s expected %h got %h", $time, name, exp, act);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    // Drive one instruction, then check both the unregistered and captured outputs
    task automatic step(input word_t instr, input word_t pc, input wb_t wb, input logic flush);
        ctrl_t exp_ctrl;
        @(posedge clk);
        instr_i <= instr;
        pc_i    <= pc;
        wb_i    <= wb;
        flush_i <= flush;
        @(negedge clk);
        check("rs1_unreg_o", instr[19:15], rs1_unreg_o);
        check("rs2_unreg_o", instr[24:20], rs2_unreg_o);
        @(posedge clk);
        wb_i    <= '0;
        flush_i <= 1'b0;
        @(negedge clk);
        exp_ctrl = expect_ctrl(instr);
        if (flush) begin
            exp_ctrl.mem_read  = 1'b0;
            exp_ctrl.mem_write = 1'b0;
            exp_ctrl.rd_write  = 1'b0;
            exp_ctrl.branch_op = `RV32_BR_NEVER;
        end
        check("ctrl_o", exp_ctrl, ctrl_o);
        check("imm_o", expect_imm(instr), imm_o);
        check("rd_o", instr[11:7], rd_o);
        check("rs1_o", instr[19:15], rs1_o);
        check("rs2_o", instr[24:20], rs2_o);
        check("pc_o", pc, pc_o);
    endtask

    function automatic word_t op_reading(input reg_addr_t a, input reg_addr_t b);
        return {7'd0, b, a, 3'd0, 5'd1, `RV32_OPC_OP};
    endfunction

    function automatic wb_t make_wb(input reg_addr_t rd, input logic we, input word_t v);
        wb_t w;
        w.rd       = rd;
        w.rd_write = we;
        w.rd_value = v;
        return w;
    endfunction

    initial begin
        int    i;
        word_t w;
        word_t held [6];
        rst_n_i = 1'b0;
        stall_i = 1'b0;
        flush_i = 1'b0;
        pc_i    = '0;
        instr_i = '0;
        wb_i    = '0;
        for (i = 0; i < 8; i++) begin
            @(negedge clk);
            check("ctrl_o", '0, ctrl_o);
            check("pc_o", '0, pc_o);
            check("imm_o", '0, imm_o);
            check("rd_o", '0, rd_o);
            check("rs1_o", '0, rs1_o);
            check("rs2_o", '0, rs2_o);
            check("rs1_value_o", '0, rs1_value_o);
            check("rs2_value_o", '0, rs2_value_o);
        end
        @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        check("ctrl_o", '0, ctrl_o);
        check("rs1_value_o", '0, rs1_value_o);

        // Fill the register file, then read every register back
        reg_model[0] = '0;
        for (i = 1; i < 32; i++) begin
            reg_model[i] = xorshift();
            step('0, '0, make_wb(i, 1'b1, reg_model[i]), 1'b0);
        end
        // x0 stays zero even when written in the cycle it is read
        step('0, '0, make_wb(0, 1'b1, 32'hdead_beef), 1'b0);
        check("rs1_value_o", '0, rs1_value_o);
        check("rs2_value_o", '0, rs2_value_o);
        for (i = 0; i < 32; i++) begin
            step(op_reading(i, 31 - i), xorshift(), '0, 1'b0);
            check("rs1_value_o", reg_model[i], rs1_value_o);
            check("rs2_value_o", reg_model[31 - i], rs2_value_o);
        end
        // Write and read of the same register in one cycle
        for (i = 0; i < 8; i++) begin
            w = xorshift();
            reg_model[w[4:0] | 5'd1] = xorshift();
            step(op_reading(w[4:0] | 5'd1, 0), '0,
                 make_wb(w[4:0] | 5'd1, 1'b1, reg_model[w[4:0] | 5'd1]), 1'b0);
            check("rs1_value_o", reg_model[w[4:0] | 5'd1], rs1_value_o);
            check("rs2_value_o", '0, rs2_value_o);
        end

        for (i = 0; i < 400; i++) begin
            step(make_instr(xorshift() % 10, xorshift()), xorshift(), '0, 1'b0);
        end
        // Unknown opcode, OP with MUL funct7, ECALL, LD
        step(32'hffff_ffff, 32'h100, '0, 1'b0);
        step(32'h0220_81b3, 32'h104, '0, 1'b0);
        check("ctrl_o", '0, ctrl_o);
        step(32'h0000_0073, 32'h108, '0, 1'b0);
        check("ctrl_o", '0, ctrl_o);
        check("imm_o", '0, imm_o);
        step(32'h0000_3003, 32'h10c, '0, 1'b0);
        check("ctrl_o", '0, ctrl_o);

        // Stall with a write to the held source register
        step(op_reading(5, 6), 32'h200, '0, 1'b0);
        held[0] = ctrl_o;
        held[1] = imm_o;
        held[2] = pc_o;
        held[3] = {rd_o, rs1_o, rs2_o};
        held[4] = rs1_value_o;
        held[5] = rs2_value_o;
        @(posedge clk);
        stall_i <= 1'b1;
        reg_model[5] = xorshift();
        wb_i <= make_wb(5, 1'b1, reg_model[5]);
        for (i = 0; i < 4; i++) begin
            instr_i <= make_instr(xorshift() % 10, xorshift());
            pc_i    <= xorshift();
            @(negedge clk);
            check("ctrl_o", held[0], ctrl_o);
            check("imm_o", held[1], imm_o);
            check("pc_o", held[2], pc_o);
            check("rd_o/rs1_o/rs2_o", held[3], {rd_o, rs1_o, rs2_o});
            check("rs1_value_o", held[4], rs1_value_o);
            check("rs2_value_o", held[5], rs2_value_o);
            @(posedge clk);
            wb_i <= '0;
        end
        stall_i <= 1'b0;
        step(op_reading(5, 6), 32'h204, '0, 1'b0);
        check("rs1_value_o", reg_model[5], rs1_value_o);

        for (i = 0; i < 100; i++) begin
            step(make_instr(xorshift() % 10, xorshift()), xorshift(), '0, 1'b1);
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+.
rv32_isa_pkg.sv
rv32_ctrl_pkg.sv
rv32_regs.sv
rv32_imm_gen.sv
rv32_ctrl_decode.sv
rv32_decode.sv
tb_rv32_decode.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_rv32_decode \
    -o sim_tb_rv32_decode

./obj_dir/sim_tb_rv32_decode > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
grep -q "STATUS: PASS" sim.log
